/* eeprom_bus_pkg.sv */
package eeprom_bus_pkg;

    // scl cycles per quarter of a bus bit
    localparam int quarter_div = 4;

    // Device type code the slave answers to
    localparam logic [3:0] dev_code = 4'b1010;

    // Bit-level commands from the master to the bit controller
    typedef enum logic [1:0]
    {
        cmd_start,
        cmd_stop,
        cmd_write,
        cmd_read
    } bit_cmd_t;

endpackage

/* eeprom_cmd_pkg.sv */
package eeprom_cmd_pkg;

    // Full memory address, page bits from the control byte plus one address byte
    localparam int addr_w = 11;
    localparam int page_w = 3;

    localparam int data_w = 8;
    localparam int code_w = 4;

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [data_w-1:0] data_t;
    typedef logic [code_w-1:0] code_t;

endpackage

/* two_wire_bit_ctrl.sv */
`timescale 1ns/10ps

module two_wire_bit_ctrl (
    input  logic                     scl,
    input  logic                     arst_n,
    input  logic                     cmd_valid,
    input  eeprom_bus_pkg::bit_cmd_t cmd,
    input  eeprom_cmd_pkg::data_t    tx_byte,
    input  logic                     tx_ack,
    input  logic                     bus_data_in,
    output logic                     cmd_done,
    output eeprom_cmd_pkg::data_t    rx_byte,
    output logic                     rx_ack,
    output logic                     clk_low,
    output logic                     data_low
);
    import eeprom_bus_pkg::*;
    import eeprom_cmd_pkg::*;

    localparam int div_w = (quarter_div > 1) ? $clog2(quarter_div) : 1;

    logic             active;
    bit_cmd_t         cmd_q;
    data_t            shift_q;
    logic             ack_q;
    logic             sample_q;
    logic [div_w-1:0] div_cnt;
    logic [1:0]       quarter;
    logic [3:0]       bit_cnt;
    logic             tick;
    logic             bit_end;
    logic             last_bit;
    logic             clk_low_d;
    logic             data_low_d;

    assign tick     = active && (div_cnt == div_w'(quarter_div - 1));
    assign bit_end  = tick && (quarter == 2'd3);
    assign last_bit = (cmd_q == cmd_start) || (cmd_q == cmd_stop) || (bit_cnt == 4'd8);

    // Line levels per quarter; clock is high in quarters 1 and 2
    always_comb
    begin
        clk_low_d  = (quarter == 2'd0) || (quarter == 2'd3);
        data_low_d = 1'b0;
        case (cmd_q)
            cmd_start:
            begin
                // Data falls between the two clock-high quarters
                data_low_d = quarter[1];
            end
            cmd_stop:
            begin
                // Clock stays released after the stop
                clk_low_d  = (quarter == 2'd0);
                data_low_d = !quarter[1];
            end
            cmd_write:
            begin
                data_low_d = (bit_cnt < 4'd8) ? !shift_q[7] : 1'b0;
            end
            default:
            begin
                data_low_d = (bit_cnt == 4'd8) ? !ack_q : 1'b0;
            end
        endcase
    end

    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            active   <= 1'b0;
            cmd_q    <= cmd_stop;
            div_cnt  <= '0;
            quarter  <= 2'd0;
            bit_cnt  <= 4'd0;
            cmd_done <= 1'b0;
            clk_low  <= 1'b0;
            data_low <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            if (!active)
            begin
                if (cmd_valid)
                begin
                    active  <= 1'b1;
                    cmd_q   <= cmd;
                    div_cnt <= '0;
                    quarter <= 2'd0;
                    bit_cnt <= 4'd0;
                end
            end
            else
            begin
                // Line levels hold while idle between commands
                clk_low  <= clk_low_d;
                data_low <= data_low_d;
                if (tick)
                begin
                    div_cnt <= '0;
                    quarter <= quarter + 2'd1;
                    if (bit_end)
                    begin
                        if (last_bit)
                        begin
                            active   <= 1'b0;
                            cmd_done <= 1'b1;
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                end
                else
                begin
                    div_cnt <= div_cnt + 1'b1;
                end
            end
        end
    end

    // Sample mid clock-high, shift MSB first at the end of each data bit
    always_ff @(posedge scl)
    begin
        if (!active && cmd_valid)
        begin
            shift_q <= tx_byte;
            ack_q   <= tx_ack;
        end
        else if (bit_end && (bit_cnt < 4'd8))
        begin
            shift_q <= {shift_q[6:0], sample_q};
        end
        if (tick && (quarter == 2'd1))
        begin
            sample_q <= bus_data_in;
        end
        // rx_ack is the raw ninth bit, low when acknowledged
        if (bit_end && last_bit)
        begin
            rx_byte <= shift_q;
            rx_ack  <= sample_q;
        end
    end

endmodule

/* eeprom_master.sv */
`timescale 1ns/10ps

module eeprom_master (
    input  logic                     scl,
    input  logic                     arst_n,
    input  logic                     start,
    input  logic                     rw,
    input  eeprom_cmd_pkg::addr_t    addr,
    input  eeprom_cmd_pkg::data_t    wdata,
    input  eeprom_cmd_pkg::code_t    ctrl_code,
    input  logic                     cmd_done,
    input  eeprom_cmd_pkg::data_t    rx_byte,
    input  logic                     rx_ack,
    output logic                     busy,
    output logic                     done,
    output logic                     nack,
    output eeprom_cmd_pkg::data_t    rdata,
    output logic                     cmd_valid,
    output eeprom_bus_pkg::bit_cmd_t cmd,
    output eeprom_cmd_pkg::data_t    tx_byte,
    output logic                     tx_ack
);
    import eeprom_bus_pkg::*;
    import eeprom_cmd_pkg::*;

    typedef enum logic [3:0]
    {
        st_idle,
        st_start,
        st_ctrl,
        st_addr,
        st_data,
        st_rstart,
        st_rctrl,
        st_read,
        st_stop
    } state_t;

    state_t state;
    logic   issued;
    logic   miss;
    logic   rw_q;
    addr_t  addr_q;
    data_t  wdata_q;
    code_t  code_q;
    logic   byte_nack;

    assign byte_nack = cmd_done && rx_ack &&
                       ((state == st_ctrl) || (state == st_addr) ||
                        (state == st_data) || (state == st_rctrl));

    // Single-byte read always ends with a not-acknowledge
    assign tx_ack = (state == st_read);

    always_comb
    begin
        cmd     = cmd_write;
        tx_byte = '0;
        case (state)
            st_start, st_rstart: cmd = cmd_start;
            st_idle, st_stop:    cmd = cmd_stop;
            st_read:             cmd = cmd_read;
            st_ctrl:             tx_byte = {code_q, addr_q[addr_w-1 -: page_w], 1'b0};
            st_rctrl:            tx_byte = {code_q, addr_q[addr_w-1 -: page_w], 1'b1};
            st_addr:             tx_byte = addr_q[addr_w-page_w-1:0];
            st_data:             tx_byte = wdata_q;
            default:             tx_byte = '0;
        endcase
    end

    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state     <= st_idle;
            issued    <= 1'b0;
            miss      <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
            nack      <= 1'b0;
            cmd_valid <= 1'b0;
        end
        else
        begin
            done      <= 1'b0;
            cmd_valid <= 1'b0;
            if (state == st_idle)
            begin
                if (start)
                begin
                    state <= st_start;
                    busy  <= 1'b1;
                    miss  <= 1'b0;
                    nack  <= 1'b0;
                end
            end
            else if (!issued)
            begin
                cmd_valid <= 1'b1;
                issued    <= 1'b1;
            end
            else if (cmd_done)
            begin
                issued <= 1'b0;
                case (state)
                    st_start:  state <= st_ctrl;
                    st_ctrl:   state <= st_addr;
                    st_addr:   state <= rw_q ? st_rstart : st_data;
                    st_data:   state <= st_stop;
                    st_rstart: state <= st_rctrl;
                    st_rctrl:  state <= st_read;
                    st_read:   state <= st_stop;
                    default:
                    begin
                        state <= st_idle;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                        nack  <= miss;
                    end
                endcase
                // Missing acknowledge goes straight to stop
                if (byte_nack)
                begin
                    miss  <= 1'b1;
                    state <= st_stop;
                end
            end
        end
    end

    always_ff @(posedge scl)
    begin
        if ((state == st_idle) && start)
        begin
            rw_q    <= rw;
            addr_q  <= addr;
            wdata_q <= wdata;
            code_q  <= ctrl_code;
        end
        if ((state == st_read) && issued && cmd_done)
        begin
            rdata <= rx_byte;
        end
    end

endmodule

/* eeprom_slave.sv */
`timescale 1ns/10ps

module eeprom_slave (
    input  logic scl,
    input  logic arst_n,
    input  logic bus_clk,
    input  logic bus_data,
    output logic data_low
);
    import eeprom_bus_pkg::*;
    import eeprom_cmd_pkg::*;

    localparam int mem_depth = 2 ** addr_w;

    typedef enum logic [2:0]
    {
        ph_idle,
        ph_ctrl,
        ph_addr,
        ph_data,
        ph_read
    } phase_t;

    data_t             mem [mem_depth];
    phase_t            phase;
    logic [2:0]        clk_sync;
    logic [2:0]        data_sync;
    logic              clk_rise;
    logic              clk_fall;
    logic              start_det;
    logic              stop_det;
    logic [3:0]        bit_cnt;
    logic              dir_q;
    logic [page_w-1:0] page_q;
    addr_t             addr_q;
    data_t             rx_q;
    data_t             tx_q;
    data_t             mem_rd;
    logic              code_ok;
    logic              byte_end;
    logic              ack_end;
    logic              mem_we;

    // Bit 1 is the synchronized level, bit 2 its previous value
    assign clk_rise  = clk_sync[1] && !clk_sync[2];
    assign clk_fall  = !clk_sync[1] && clk_sync[2];
    assign start_det = clk_sync[1] && clk_sync[2] && data_sync[2] && !data_sync[1];
    assign stop_det  = clk_sync[1] && clk_sync[2] && !data_sync[2] && data_sync[1];

    // Falls after the eighth and the ninth clock of a byte
    assign byte_end = clk_fall && (bit_cnt == 4'd8);
    assign ack_end  = clk_fall && (bit_cnt == 4'd9);

    assign code_ok = (rx_q[data_w-1 -: code_w] == dev_code);
    assign mem_we  = byte_end && (phase == ph_data);
    assign mem_rd  = mem[addr_q];

    always_ff @(posedge scl or negedge arst_n)
    begin
        if (!arst_n)
        begin
            clk_sync  <= 3'b111;
            data_sync <= 3'b111;
            phase     <= ph_idle;
            bit_cnt   <= 4'd0;
            data_low  <= 1'b0;
        end
        else
        begin
            clk_sync  <= {clk_sync[1:0], bus_clk};
            data_sync <= {data_sync[1:0], bus_data};
            if (start_det)
            begin
                phase    <= ph_ctrl;
                bit_cnt  <= 4'd0;
                data_low <= 1'b0;
            end
            else if (stop_det)
            begin
                phase    <= ph_idle;
                bit_cnt  <= 4'd0;
                data_low <= 1'b0;
            end
            else if (phase != ph_idle)
            begin
                if (clk_rise && (bit_cnt != 4'd9))
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
                if (byte_end)
                begin
                    case (phase)
                        ph_ctrl:
                        begin
                            // Another device code, stay off the bus until next start
                            data_low <= code_ok;
                            if (!code_ok)
                            begin
                                phase <= ph_idle;
                            end
                        end
                        ph_read: data_low <= 1'b0;
                        default: data_low <= 1'b1;
                    endcase
                end
                else if (ack_end)
                begin
                    bit_cnt  <= 4'd0;
                    data_low <= 1'b0;
                    case (phase)
                        ph_ctrl:
                        begin
                            if (dir_q)
                            begin
                                phase    <= ph_read;
                                data_low <= !mem_rd[7];
                            end
                            else
                            begin
                                phase <= ph_addr;
                            end
                        end
                        ph_addr: phase <= ph_data;
                        default: phase <= ph_idle;
                    endcase
                end
                else if (clk_fall && (phase == ph_read) && (bit_cnt != 4'd0))
                begin
                    data_low <= !tx_q[6];
                end
            end
        end
    end

    always_ff @(posedge scl)
    begin
        if (clk_rise && (bit_cnt < 4'd8))
        begin
            rx_q <= {rx_q[6:0], data_sync[1]};
        end
        if (byte_end && (phase == ph_ctrl))
        begin
            page_q <= rx_q[page_w:1];
            dir_q  <= rx_q[0];
        end
        if (byte_end && (phase == ph_addr))
        begin
            addr_q <= {page_q, rx_q};
        end
        if (ack_end && (phase == ph_ctrl))
        begin
            tx_q <= mem_rd;
        end
        else if (clk_fall && (phase == ph_read))
        begin
            tx_q <= {tx_q[6:0], 1'b0};
        end
        if (mem_we)
        begin
            mem[addr_q] <= rx_q;
        end
    end

endmodule

/* eeprom_subsystem.sv */
`timescale 1ns/10ps

module eeprom_subsystem (
    input  logic                  scl,
    input  logic                  arst_n,
    input  logic                  start,
    input  logic                  rw,
    input  eeprom_cmd_pkg::addr_t addr,
    input  eeprom_cmd_pkg::data_t wdata,
    input  eeprom_cmd_pkg::code_t ctrl_code,
    output logic                  busy,
    output logic                  done,
    output logic                  nack,
    output eeprom_cmd_pkg::data_t rdata,
    output logic                  bus_clk,
    output logic                  bus_data
);
    import eeprom_bus_pkg::*;
    import eeprom_cmd_pkg::*;

    logic     cmd_valid;
    bit_cmd_t cmd;
    data_t    tx_byte;
    logic     tx_ack;
    logic     cmd_done;
    data_t    rx_byte;
    logic     rx_ack;
    logic     clk_low;
    logic     ctrl_data_low;
    logic     slave_data_low;

    // Open-drain lines, high unless a side pulls low
    assign bus_clk  = !clk_low;
    assign bus_data = !(ctrl_data_low || slave_data_low);

    eeprom_master eeprom_master_i (
        .scl       (scl),
        .arst_n    (arst_n),
        .start     (start),
        .rw        (rw),
        .addr      (addr),
        .wdata     (wdata),
        .ctrl_code (ctrl_code),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .rx_ack    (rx_ack),
        .busy      (busy),
        .done      (done),
        .nack      (nack),
        .rdata     (rdata),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .tx_ack    (tx_ack)
    );

    two_wire_bit_ctrl two_wire_bit_ctrl_i (
        .scl         (scl),
        .arst_n      (arst_n),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .tx_byte     (tx_byte),
        .tx_ack      (tx_ack),
        .bus_data_in (bus_data),
        .cmd_done    (cmd_done),
        .rx_byte     (rx_byte),
        .rx_ack      (rx_ack),
        .clk_low     (clk_low),
        .data_low    (ctrl_data_low)
    );

    eeprom_slave eeprom_slave_i (
        .scl      (scl),
        .arst_n   (arst_n),
        .bus_clk  (bus_clk),
        .bus_data (bus_data),
        .data_low (slave_data_low)
    );

endmodule

/* eeprom_props.sv */
`timescale 1ns/10ps

module eeprom_props (
    input logic scl,
    input logic arst_n,
    input logic start,
    input logic busy,
    input logic done,
    input logic nack
);

    int done_fail = 0;
    int nack_fail = 0;
    int busy_fail = 0;

    // Done only ends a transfer that was running
    done_after_busy: assert property (@(posedge scl) disable iff (!arst_n)
        done |-> $past(busy))
    else
    begin
        $error("done without busy in the previous cycle");
        done_fail++;
    end

    // Nack set by done, then held while idle
    nack_held: assert property (@(posedge scl) disable iff (!arst_n)
        nack |-> (done || ($past(nack) && !busy)))
    else
    begin
        $error("nack high outside a done cycle or its hold");
        nack_fail++;
    end

    start_raises_busy: assert property (@(posedge scl) disable iff (!arst_n)
        (start && !busy) |=> busy)
    else
    begin
        $error("accepted start did not raise busy");
        busy_fail++;
    end

endmodule

bind eeprom_master eeprom_props eeprom_props_i (
    .scl    (scl),
    .arst_n (arst_n),
    .start  (start),
    .busy   (busy),
    .done   (done),
    .nack   (nack)
);

/* tb_eeprom_subsystem.sv */
`timescale 1ns/10ps

module tb_eeprom_subsystem;
    import eeprom_cmd_pkg::*;

    localparam int half_period  = 10;
    localparam int drive_delay  = 2;
    localparam int reset_cycles = 4;
    localparam int done_limit   = 3000;
    localparam int quiet_cycles = 700;
    localparam int max_steps    = 80;
    localparam int random_pairs = 20;

    localparam code_t good_code = 4'b1010;
    localparam code_t bad_code  = 4'b0110;

    localparam logic [1:0] op_write      = 2'd0;
    localparam logic [1:0] op_read       = 2'd1;
    localparam logic [1:0] op_busy_write = 2'd2;

    logic  scl;
    logic  arst_n;
    logic  start;
    logic  rw;
    addr_t addr;
    data_t wdata;
    code_t ctrl_code;
    logic  busy;
    logic  done;
    logic  nack;
    data_t rdata;
    logic  bus_clk;
    logic  bus_data;

    // Stimulus and expected results, one entry per transfer
    logic [1:0] step_op    [max_steps];
    addr_t      step_addr  [max_steps];
    data_t      step_wdata [max_steps];
    code_t      step_code  [max_steps];
    logic       step_nack  [max_steps];
    data_t      step_rdata [max_steps];

    int step_count;
    int check_errors;
    int timeouts;
    int seed;

    eeprom_subsystem eeprom_subsystem_i (
        .scl       (scl),
        .arst_n    (arst_n),
        .start     (start),
        .rw        (rw),
        .addr      (addr),
        .wdata     (wdata),
        .ctrl_code (ctrl_code),
        .busy      (busy),
        .done      (done),
        .nack      (nack),
        .rdata     (rdata),
        .bus_clk   (bus_clk),
        .bus_data  (bus_data)
    );

    always
    begin
        #half_period;
        scl = !scl;
    end

    // One address per page, spread over the low byte
    function automatic addr_t page_addr(input int page);
        return addr_t'(page * 256 + 16 + page * 3);
    endfunction

    function automatic data_t page_data(input int page);
        return data_t'(8'h5a + page * 8'h13);
    endfunction

    function automatic int assertion_failures();
        return eeprom_subsystem_i.eeprom_master_i.eeprom_props_i.done_fail +
               eeprom_subsystem_i.eeprom_master_i.eeprom_props_i.nack_fail +
               eeprom_subsystem_i.eeprom_master_i.eeprom_props_i.busy_fail;
    endfunction

    task automatic check_data(input string name, input data_t seen, input data_t expected);
        if (seen !== expected)
        begin
            $display("CHECK FAILED at %0t: %s seen %h expected %h",
                     $time, name, seen, expected);
            check_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic seen, input logic expected);
        if (seen !== expected)
        begin
            $display("CHECK FAILED at %0t: %s seen %b expected %b",
                     $time, name, seen, expected);
            check_errors++;
        end
    endtask

    task automatic add_step(input logic [1:0] op, input addr_t a, input data_t d,
                            input code_t c, input logic exp_nack, input data_t exp_rdata);
        step_op[step_count]    = op;
        step_addr[step_count]  = a;
        step_wdata[step_count] = d;
        step_code[step_count]  = c;
        step_nack[step_count]  = exp_nack;
        step_rdata[step_count] = exp_rdata;
        step_count++;
    endtask

    task automatic build_table();
        addr_t a;
        data_t d;
        for (int p = 0; p < 8; p++)
        begin
            add_step(op_write, page_addr(p), page_data(p), good_code, 1'b0, '0);
        end
        for (int p = 0; p < 8; p++)
        begin
            add_step(op_read, page_addr(p), '0, good_code, 1'b0, page_data(p));
        end
        // Overwrite in page 3
        add_step(op_write, page_addr(3), 8'hc3, good_code, 1'b0, '0);
        add_step(op_read, page_addr(3), '0, good_code, 1'b0, 8'hc3);
        // Foreign device code leaves page 5 alone
        add_step(op_write, page_addr(5), 8'hee, bad_code, 1'b1, '0);
        add_step(op_read, page_addr(5), '0, bad_code, 1'b1, '0);
        add_step(op_read, page_addr(5), '0, good_code, 1'b0, page_data(5));
        // Second start aims at page 1 while busy
        add_step(op_busy_write, page_addr(6), 8'h6b, good_code, 1'b0, '0);
        add_step(op_read, page_addr(6), '0, good_code, 1'b0, 8'h6b);
        add_step(op_read, page_addr(1), '0, good_code, 1'b0, page_data(1));
        for (int n = 0; n < random_pairs; n++)
        begin
            a = addr_t'($random(seed));
            d = data_t'($random(seed));
            add_step(op_write, a, d, good_code, 1'b0, '0);
            add_step(op_read, a, '0, good_code, 1'b0, d);
        end
    endtask

    task automatic pulse_start(input logic r, input addr_t a, input data_t d, input code_t c);
        start     = 1'b1;
        rw        = r;
        addr      = a;
        wdata     = d;
        ctrl_code = c;
        @(posedge scl);
        #drive_delay;
        start = 1'b0;
    endtask

    task automatic wait_done(output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && (cycles < done_limit))
        begin
            @(posedge scl);
            #drive_delay;
            seen = (done === 1'b1);
            cycles++;
        end
        if (!seen)
        begin
            $display("ERROR at %0t: no done within limit", $time);
            timeouts++;
        end
    endtask

    task automatic count_extra_done(output int extra);
        int cycles;
        extra  = 0;
        cycles = 0;
        while (cycles < quiet_cycles)
        begin
            @(posedge scl);
            #drive_delay;
            if (done === 1'b1)
            begin
                extra++;
            end
            cycles++;
        end
    endtask

    task automatic run_step(input int i, output logic ok);
        logic seen;
        int   extra;
        ok = 1'b1;
        pulse_start(step_op[i] == op_read, step_addr[i], step_wdata[i], step_code[i]);
        check_flag("busy", busy, 1'b1);
        if (step_op[i] == op_busy_write)
        begin
            repeat (3) @(posedge scl);
            #drive_delay;
            check_flag("busy", busy, 1'b1);
            pulse_start(1'b0, page_addr(1), ~step_wdata[i], good_code);
        end
        wait_done(seen);
        if (!seen)
        begin
            ok = 1'b0;
        end
        else
        begin
            check_flag("nack", nack, step_nack[i]);
            check_flag("busy", busy, 1'b0);
            if ((step_op[i] == op_read) && !step_nack[i])
            begin
                check_data("rdata", rdata, step_rdata[i]);
            end
            if (step_op[i] == op_busy_write)
            begin
                count_extra_done(extra);
                if (extra != 0)
                begin
                    $display("ERROR at %0t: %0d more done pulses after the start given while busy",
                             $time, extra);
                    check_errors++;
                end
            end
        end
    endtask

    initial
    begin
        logic ok;
        int   failures;
        scl          = 1'b0;
        arst_n       = 1'b0;
        start        = 1'b0;
        rw           = 1'b0;
        addr         = '0;
        wdata        = '0;
        ctrl_code    = '0;
        check_errors = 0;
        timeouts     = 0;
        step_count   = 0;
        seed         = 2;
        build_table();

        repeat (reset_cycles) @(posedge scl);
        #drive_delay;
        arst_n = 1'b1;
        @(posedge scl);
        #drive_delay;

        // Idle state after reset
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("nack", nack, 1'b0);
        check_flag("bus_clk", bus_clk, 1'b1);
        check_flag("bus_data", bus_data, 1'b1);

        ok = 1'b1;
        for (int i = 0; (i < step_count) && ok; i++)
        begin
            run_step(i, ok);
            @(posedge scl);
            #drive_delay;
        end

        failures = check_errors + timeouts + assertion_failures();
        $display("Report: %0d check errors, %0d timeouts, %0d assertion failures",
                 check_errors, timeouts, assertion_failures());
        if (failures == 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* sim.f */
eeprom_bus_pkg.sv
eeprom_cmd_pkg.sv
two_wire_bit_ctrl.sv
eeprom_master.sv
eeprom_slave.sv
eeprom_subsystem.sv
eeprom_props.sv
tb_eeprom_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_eeprom_subsystem
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= All tests passed

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS) 2>&1)"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
